//--- flist.f
+incdir+source
+incdir+test
source/board_pkg.sv
source/bus_arbiter.sv
source/sys_block.sv
source/gpio_bank.sv
source/led_sweep.sv
source/board_top.sv
test/tb_board_top.sv

//--- run_sim.sh
#!/bin/sh
# Build the board testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module tb_board_top -f flist.f

status=0
./obj_dir/Vtb_board_top > sim.log 2>&1 || status=$?
cat sim.log

# Failure shows up in the log or as a bad exit code
if [ "$status" -ne 0 ] || grep -q "test failed" sim.log; then
  exit 1
fi
exit 0

//--- test/tb_board_model.svh
`ifndef TB_BOARD_MODEL_SVH
`define TB_BOARD_MODEL_SVH

// Shadow copies of what the host has written
logic [`BUS_DW-1:0]              sh_scratch;
logic [`RATE_W-1:0]              sh_rate;
logic [`GPIO_WORDS*`BUS_DW-1:0]  sh_out [2];
logic [`GPIO_WORDS*`BUS_DW-1:0]  sh_oe [2];
// Pin levels last driven by the testbench
logic [`GPIO_COUNT-1:0]          sh_in [2];

task automatic model_reset();
  sh_scratch = '0;
  sh_rate    = '0;
  for (int b = 0; b < 2; b++) begin
    sh_out[b] = '0;
    sh_oe[b]  = '0;
    sh_in[b]  = '0;
  end
endtask

// Only the three slave pages decode
function automatic logic page_mapped(input logic [15:0] page);
  return page == `SYS_PAGE || page == `ZDOK0_PAGE || page == `ZDOK1_PAGE;
endfunction

// Expected read data for one address
function automatic logic [31:0] exp_read(input logic [31:0] a);
  logic [15:0] page;
  logic [13:0] idx;
  logic [95:0] vec;
  int          bank;
  page = a[31:16];
  idx  = a[15:2];
  if (page == `SYS_PAGE) begin
    case (idx)
      14'd0:   return `BOARD_ID;
      14'd1:   return sh_scratch;
      14'd2:   return 32'(sh_rate);
      default: return '0;
    endcase
  end
  // Unmapped pages, high index bits and word 3 all read zero
  if (!page_mapped(page) || idx[13:4] != '0 || idx[1:0] == 2'd3) return '0;
  bank = (page == `ZDOK0_PAGE) ? 0 : 1;
  case (idx[3:2])
    2'd0:    vec = sh_out[bank];
    2'd1:    vec = sh_oe[bank];
    2'd2:    vec = 96'(sh_in[bank]);
    default: vec = '0;
  endcase
  return vec[idx[1:0]*32 +: 32];
endfunction

// Shadow update for a mapped write
task automatic model_write(input logic [31:0] a, input logic [3:0] s, input logic [31:0] d);
  logic [15:0] page;
  logic [13:0] idx;
  logic [95:0] msk;
  logic [95:0] vec;
  int          bank;
  page = a[31:16];
  idx  = a[15:2];
  msk  = '0;
  if (page == `SYS_PAGE && idx == 14'd1) begin
    for (int b = 0; b < 4; b++) begin
      if (s[b]) sh_scratch[b*8 +: 8] = d[b*8 +: 8];
    end
  end
  // Rate lives in lane 0
  if (page == `SYS_PAGE && idx == 14'd2 && s[0]) sh_rate = d[`RATE_W-1:0];
  if (page != `SYS_PAGE && idx[13:3] == '0 && idx[1:0] != 2'd3) begin
    bank = (page == `ZDOK0_PAGE) ? 0 : 1;
    for (int b = 0; b < 4; b++) begin
      if (s[b]) msk[idx[1:0]*32 + b*8 +: 8] = 8'hff;
    end
    // Nothing above pin 79 holds a value
    msk = msk & 96'({`GPIO_COUNT{1'b1}});
    vec = 96'(d) << (idx[1:0] * 32);
    if (idx[2]) sh_oe[bank] = (sh_oe[bank] & ~msk) | (vec & msk);
    else sh_out[bank] = (sh_out[bank] & ~msk) | (vec & msk);
  end
endtask

// Step on the last cycle of each period, counted from reset
function automatic logic led_step(input int unsigned cnt, input logic [`RATE_W-1:0] rate);
  int unsigned period;
  period = 1 << (`LED_BASE_SHIFT + rate);
  return (cnt % period) == (period - 1);
endfunction

// Next {direction, position}, turning at both ends
function automatic logic [3:0] led_next(input logic [2:0] pos, input logic up);
  if (up && pos == 3'(`LED_COUNT - 1)) return {1'b0, pos - 3'd1};
  if (!up && pos == 3'd0) return {1'b1, 3'd1};
  return up ? {1'b1, pos + 3'd1} : {1'b0, pos - 3'd1};
endfunction

`endif

//--- test/tb_board_top.sv
`include "board_defs.svh"

module tb_board_top;

  import board_pkg::*;

  localparam int unsigned SEED       = 32'hb69c05a5;
  // Bus accesses issued, rounded up
  localparam int          N_ACCESS   = 60;
  localparam int          LED_CYCLES = 600;
  localparam int          WATCHDOG_T = (N_ACCESS * (`BUS_TIMEOUT + 4) + LED_CYCLES) * 8;

  logic                   clk_125;
  logic                   rst_n_i;
  bus_req_t               host_req;
  bus_rsp_t               host_rsp;
  logic [`GPIO_COUNT-1:0] zdok0_out;
  logic [`GPIO_COUNT-1:0] zdok0_oe;
  logic [`GPIO_COUNT-1:0] zdok1_out;
  logic [`GPIO_COUNT-1:0] zdok1_oe;
  logic [`GPIO_COUNT-1:0] zdok_in [2];
  logic [`LED_COUNT-1:0]  led;

  // Pending comparisons
  logic [95:0] got_q [$];
  logic [95:0] exp_q [$];
  string       name_q [$];
  logic [95:0] got_v;
  logic [95:0] exp_v;
  string       name_v;
  int          value_errs;
  int          other_errs;
  // LED model state
  int unsigned led_cnt;
  logic [2:0]  led_pos;
  logic        led_up;
  logic [31:0] adr;

  `include "tb_board_model.svh"

  board_top UUT (
    .clk_125     (clk_125),
    .rst_n_i     (rst_n_i),
    .host_req_i  (host_req),
    .host_rsp_o  (host_rsp),
    .zdok0_out_o (zdok0_out),
    .zdok0_oe_o  (zdok0_oe),
    .zdok0_in_i  (zdok_in[0]),
    .zdok1_out_o (zdok1_out),
    .zdok1_oe_o  (zdok1_oe),
    .zdok1_in_i  (zdok_in[1]),
    .led_o       (led)
  );

  initial begin
    clk_125 = 1'b0;
    forever #4 clk_125 = ~clk_125;
  end

  initial begin
    #(WATCHDOG_T);
    $display("Watchdog expired before all tests finished");
    $display("test failed");
    $finish;
  end

  task automatic queue_check(input string name, input logic [95:0] got, input logic [95:0] exp);
    name_q.push_back(name);
    got_q.push_back(got);
    exp_q.push_back(exp);
  endtask

  // Compare at the falling edge, away from any drive
  always @(negedge clk_125) begin
    while (got_q.size() != 0) begin
      got_v  = got_q.pop_front();
      exp_v  = exp_q.pop_front();
      name_v = name_q.pop_front();
      assert (got_v === exp_v) else begin
        $display("** Error %s: got %h, expected %h", name_v, got_v, exp_v);
        value_errs++;
      end
    end
    // LED position every cycle out of reset
    if (rst_n_i) begin
      assert (led === (`LED_COUNT'(1) << led_pos)) else begin
        $display("** Error led_o: got %h, expected %h", led, `LED_COUNT'(1) << led_pos);
        value_errs++;
      end
    end
  end

  // Reference LED sweep, same count base as the DUT prescaler
  always @(posedge clk_125) begin
    if (!rst_n_i) begin
      led_cnt <= 0;
      led_pos <= '0;
      led_up  <= 1'b1;
    end else begin
      led_cnt <= led_cnt + 1;
      if (led_step(led_cnt, sh_rate)) {led_up, led_pos} <= led_next(led_pos, led_up);
    end
  end

  function automatic logic [31:0] reg_addr(input logic [15:0] page, input int idx);
    return {page, 14'(idx), 2'b00};
  endfunction

  function automatic logic [31:0] gpio_addr(input int bank, input int kind, input int word);
    return {bank == 0 ? `ZDOK0_PAGE : `ZDOK1_PAGE, 10'd0, 2'(kind), 2'(word), 2'b00};
  endfunction

  // One host access, stb held until ack or err
  task automatic bus_access(input logic we_in, input logic [31:0] a, input logic [3:0] s,
                            input logic [31:0] d, output logic [31:0] q);
    int   cycles;
    logic mapped;
    mapped        = page_mapped(a[31:16]);
    host_req.stb  = 1'b1;
    host_req.we   = we_in;
    host_req.sel  = s;
    host_req.adr  = a;
    host_req.dat  = d;
    cycles        = 0;
    while (!(host_rsp.ack || host_rsp.err) && cycles <= `BUS_TIMEOUT + 4) begin
      @(posedge clk_125);
      #1;
      cycles++;
    end
    q = host_rsp.dat;
    assert (host_rsp.ack || host_rsp.err) else begin
      $display("No ack or err came back for the access at address %h", a);
      other_errs++;
    end
    if (mapped) begin
      queue_check("host_rsp_o.ack", host_rsp.ack, 1);
      queue_check("host_rsp_o.ack latency", cycles, 2);
    end else begin
      queue_check("host_rsp_o.err", host_rsp.err, 1);
      queue_check("host_rsp_o.ack", host_rsp.ack, 0);
      queue_check("host_rsp_o.err latency", cycles, `BUS_TIMEOUT);
      queue_check("host_rsp_o.dat", host_rsp.dat, 0);
    end
    if (mapped && we_in) model_write(a, s, d);
    // Drop stb the cycle after the response
    @(posedge clk_125);
    #1;
    host_req = '0;
  endtask

  task automatic write_reg(input logic [31:0] a, input logic [3:0] s, input logic [31:0] d);
    logic [31:0] unused;
    bus_access(1'b1, a, s, d, unused);
  endtask

  task automatic read_check(input logic [31:0] a);
    logic [31:0] q;
    bus_access(1'b0, a, 4'h0, 32'h0, q);
    queue_check("host_rsp_o.dat", q, exp_read(a));
  endtask

  // Set a rate, then wait for a full bounce
  task automatic sweep_check(input logic [`RATE_W-1:0] rate, input int cycles);
    logic seen_top;
    logic seen_back;
    write_reg(reg_addr(`SYS_PAGE, 2), 4'h1, 32'(rate));
    read_check(reg_addr(`SYS_PAGE, 2));
    seen_top  = 1'b0;
    seen_back = 1'b0;
    repeat (cycles) begin
      @(posedge clk_125);
      #1;
      if (led[`LED_COUNT-1]) seen_top = 1'b1;
      if (seen_top && led[0]) seen_back = 1'b1;
    end
    assert (seen_back) else begin
      $display("LED did not run from bit 0 to bit 7 and back at rate %0d", rate);
      other_errs++;
    end
  endtask

  initial begin
    void'($urandom(SEED));
    rst_n_i    = 1'b0;
    host_req   = '0;
    zdok_in[0] = '0;
    zdok_in[1] = '0;
    value_errs = 0;
    other_errs = 0;
    model_reset();
    repeat (5) @(posedge clk_125);
    #1;
    rst_n_i = 1'b1;

    // Reset state
    queue_check("host_rsp_o.ack", host_rsp.ack, 0);
    queue_check("host_rsp_o.err", host_rsp.err, 0);
    queue_check("zdok0_out_o", zdok0_out, 0);
    queue_check("zdok0_oe_o", zdok0_oe, 0);
    queue_check("zdok1_out_o", zdok1_out, 0);
    queue_check("zdok1_oe_o", zdok1_oe, 0);
    queue_check("led_o", led, 1);
    read_check(reg_addr(`SYS_PAGE, 0));
    read_check(reg_addr(`SYS_PAGE, 1));

    // Scratch, random lanes
    repeat (8) begin
      write_reg(reg_addr(`SYS_PAGE, 1), 4'($urandom), $urandom);
      read_check(reg_addr(`SYS_PAGE, 1));
    end

    // Output and enable words of both banks
    for (int bank = 0; bank < 2; bank++) begin
      for (int kind = 0; kind < 2; kind++) begin
        for (int word = 0; word < `GPIO_WORDS; word++) begin
          adr = gpio_addr(bank, kind, word);
          write_reg(adr, 4'($urandom), $urandom);
          read_check(adr);
        end
      end
    end
    queue_check("zdok0_out_o", zdok0_out, sh_out[0][`GPIO_COUNT-1:0]);
    queue_check("zdok0_oe_o", zdok0_oe, sh_oe[0][`GPIO_COUNT-1:0]);
    queue_check("zdok1_out_o", zdok1_out, sh_out[1][`GPIO_COUNT-1:0]);
    queue_check("zdok1_oe_o", zdok1_oe, sh_oe[1][`GPIO_COUNT-1:0]);

    // Input pins, read after the synchronizer settles
    zdok_in[0] = `GPIO_COUNT'({$urandom, $urandom, $urandom});
    zdok_in[1] = `GPIO_COUNT'({$urandom, $urandom, $urandom});
    sh_in[0]   = zdok_in[0];
    sh_in[1]   = zdok_in[1];
    repeat (3) @(posedge clk_125);
    #1;
    for (int bank = 0; bank < 2; bank++) begin
      for (int word = 0; word < `GPIO_WORDS; word++) begin
        read_check(gpio_addr(bank, 2, word));
      end
    end

    // Hole in the map, then a normal access
    read_check(reg_addr(16'h0007, 0));
    read_check(reg_addr(`SYS_PAGE, 0));

    sweep_check(3'd0, 120);
    sweep_check(3'd2, 400);

    repeat (2) @(posedge clk_125);
    #1;
    $display("Errors: %0d value mismatches, %0d other failures", value_errs, other_errs);
    if (value_errs == 0 && other_errs == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

//--- source/board_top.sv
`include "board_defs.svh"

module board_top (
  input  logic                   clk_125,
  input  logic                   rst_n_i,
  input  board_pkg::bus_req_t    host_req_i,
  output board_pkg::bus_rsp_t    host_rsp_o,
  output logic [`GPIO_COUNT-1:0] zdok0_out_o,
  output logic [`GPIO_COUNT-1:0] zdok0_oe_o,
  input  logic [`GPIO_COUNT-1:0] zdok0_in_i,
  output logic [`GPIO_COUNT-1:0] zdok1_out_o,
  output logic [`GPIO_COUNT-1:0] zdok1_oe_o,
  input  logic [`GPIO_COUNT-1:0] zdok1_in_i,
  output logic [`LED_COUNT-1:0]  led_o
);

  import board_pkg::*;

  // Per-slave bus legs
  bus_req_t           slv_req [`NUM_SLAVES];
  bus_rsp_t           slv_rsp [`NUM_SLAVES];
  logic [`RATE_W-1:0] led_rate;

  bus_arbiter u_arbiter (
    .clk_125    (clk_125),
    .rst_n_i    (rst_n_i),
    .host_req_i (host_req_i),
    .host_rsp_o (host_rsp_o),
    .slv_req_o  (slv_req),
    .slv_rsp_i  (slv_rsp)
  );

  sys_block u_sys (
    .clk_125    (clk_125),
    .rst_n_i    (rst_n_i),
    .req_i      (slv_req[`SLV_SYS]),
    .rsp_o      (slv_rsp[`SLV_SYS]),
    .led_rate_o (led_rate)
  );

  // Mezzanine 0
  gpio_bank #(
    .COUNT (`GPIO_COUNT)
  ) u_zdok0 (
    .clk_125   (clk_125),
    .rst_n_i   (rst_n_i),
    .req_i     (slv_req[`SLV_ZDOK0]),
    .rsp_o     (slv_rsp[`SLV_ZDOK0]),
    .pin_out_o (zdok0_out_o),
    .pin_oe_o  (zdok0_oe_o),
    .pin_in_i  (zdok0_in_i)
  );

  // Mezzanine 1
  gpio_bank #(
    .COUNT (`GPIO_COUNT)
  ) u_zdok1 (
    .clk_125   (clk_125),
    .rst_n_i   (rst_n_i),
    .req_i     (slv_req[`SLV_ZDOK1]),
    .rsp_o     (slv_rsp[`SLV_ZDOK1]),
    .pin_out_o (zdok1_out_o),
    .pin_oe_o  (zdok1_oe_o),
    .pin_in_i  (zdok1_in_i)
  );

  led_sweep u_leds (
    .clk_125 (clk_125),
    .rst_n_i (rst_n_i),
    .rate_i  (led_rate),
    .led_o   (led_o)
  );

endmodule

//--- source/led_sweep.sv
`include "board_defs.svh"

module led_sweep (
  input  logic                  clk_125,
  input  logic                  rst_n_i,
  input  logic [`RATE_W-1:0]    rate_i,
  output logic [`LED_COUNT-1:0] led_o
);

  // Enough bits for the slowest period
  localparam int PRE_W = `LED_BASE_SHIFT + (1 << `RATE_W) - 1;

  logic [PRE_W-1:0]      pre_q;
  logic [PRE_W-1:0]      step_mask;
  logic                  step;
  logic                  up_q;
  logic [`LED_COUNT-1:0] led_q;

  // Step when the low exponent bits are all ones
  // Free-running from reset, so steps stay reset aligned
  assign step_mask = (PRE_W'(1) << (`LED_BASE_SHIFT + rate_i)) - 1'b1;
  assign step      = (pre_q & step_mask) == step_mask;

  always_ff @(posedge clk_125) begin
    if (!rst_n_i) begin
      pre_q <= '0;
      up_q  <= 1'b1;
      led_q <= `LED_COUNT'(1);
    end else begin
      pre_q <= pre_q + 1'b1;
      if (step) begin
        // Bounce off either end
        if (up_q && led_q[`LED_COUNT-1]) begin
          led_q <= led_q >> 1;
          up_q  <= 1'b0;
        end else if (!up_q && led_q[0]) begin
          led_q <= led_q << 1;
          up_q  <= 1'b1;
        end else begin
          led_q <= up_q ? led_q << 1 : led_q >> 1;
        end
      end
    end
  end

  assign led_o = led_q;

  // Exactly one LED lit at all times
  a_led_onehot: assert property (@(posedge clk_125) disable iff (!rst_n_i)
    $onehot(led_q));

endmodule

//--- source/gpio_bank.sv
`include "board_defs.svh"

module gpio_bank #(
  parameter int COUNT = `GPIO_COUNT
) (
  input  logic                clk_125,
  input  logic                rst_n_i,
  input  board_pkg::bus_req_t req_i,
  output board_pkg::bus_rsp_t rsp_o,
  output logic [COUNT-1:0]    pin_out_o,
  output logic [COUNT-1:0]    pin_oe_o,
  input  logic [COUNT-1:0]    pin_in_i
);

  localparam int DW     = `BUS_DW;
  localparam int FULL_W = `GPIO_WORDS * DW;
  // Register kinds in idx[3:2]
  localparam logic [1:0] KIND_OUT = 2'd0;
  localparam logic [1:0] KIND_OE  = 2'd1;
  localparam logic [1:0] KIND_IN  = 2'd2;
  // Only real pins are writable
  localparam logic [FULL_W-1:0] PIN_MASK = FULL_W'({COUNT{1'b1}});

  logic              acc;
  logic              wr;
  logic [1:0]        kind;
  logic [1:0]        word;
  logic              word_ok;
  logic [FULL_W-1:0] wr_vec;
  logic [FULL_W-1:0] wr_msk;
  logic [FULL_W-1:0] rd_vec;
  logic [FULL_W-1:0] out_q;
  logic [FULL_W-1:0] oe_q;
  logic [COUNT-1:0]  in_meta_q;
  logic [COUNT-1:0]  in_sync_q;
  logic              ack_q;
  logic [DW-1:0]     rd_q;

  assign acc     = req_i.stb && !ack_q;
  assign wr      = acc && req_i.we;
  assign kind    = req_i.adr.fld.idx[3:2];
  assign word    = req_i.adr.fld.idx[1:0];
  // Upper index bits must be clear
  assign word_ok = req_i.adr.fld.idx[13:4] == '0 && word < `GPIO_WORDS;

  // Place bus word and lane mask at the addressed word
  always_comb begin
    wr_vec = '0;
    wr_msk = '0;
    if (word_ok) begin
      wr_vec[word*DW +: DW] = req_i.dat;
      for (int b = 0; b < DW / 8; b++) begin
        wr_msk[word*DW + b*8 +: 8] = {8{req_i.sel[b]}};
      end
    end
    wr_msk = wr_msk & PIN_MASK;
  end

  always_ff @(posedge clk_125) begin
    if (!rst_n_i) begin
      ack_q <= 1'b0;
      out_q <= '0;
      oe_q  <= '0;
    end else begin
      ack_q <= acc;
      if (wr && kind == KIND_OUT) out_q <= (out_q & ~wr_msk) | (wr_vec & wr_msk);
      if (wr && kind == KIND_OE)  oe_q  <= (oe_q & ~wr_msk) | (wr_vec & wr_msk);
    end
  end

  // Two-flop input sync
  always_ff @(posedge clk_125) begin
    in_meta_q <= pin_in_i;
    in_sync_q <= in_meta_q;
  end

  // Input kind is read-only, spare bits read zero
  always_comb begin
    case (kind)
      KIND_OUT: rd_vec = out_q;
      KIND_OE:  rd_vec = oe_q;
      KIND_IN:  rd_vec = FULL_W'(in_sync_q);
      default:  rd_vec = '0;
    endcase
  end

  always_ff @(posedge clk_125) begin
    if (acc) rd_q <= word_ok ? rd_vec[word*DW +: DW] : '0;
  end

  assign rsp_o     = '{ack: ack_q, err: 1'b0, dat: rd_q};
  assign pin_out_o = out_q[COUNT-1:0];
  assign pin_oe_o  = oe_q[COUNT-1:0];

  // No ack without a strobe the cycle before
  a_ack_after_stb: assert property (@(posedge clk_125) disable iff (!rst_n_i)
    ack_q |-> $past(req_i.stb));

endmodule

//--- source/sys_block.sv
`include "board_defs.svh"

module sys_block (
  input  logic                clk_125,
  input  logic                rst_n_i,
  input  board_pkg::bus_req_t req_i,
  output board_pkg::bus_rsp_t rsp_o,
  output logic [`RATE_W-1:0]  led_rate_o
);

  localparam int DW          = `BUS_DW;
  localparam int REG_ID      = 0;
  localparam int REG_SCRATCH = 1;
  localparam int REG_RATE    = 2;

  logic          acc;
  logic          wr;
  logic [13:0]   idx;
  logic          ack_q;
  logic [DW-1:0] rd_q;
  logic [DW-1:0] scratch_q;
  logic [`RATE_W-1:0] rate_q;

  // New access only in the cycle before ack
  assign acc = req_i.stb && !ack_q;
  assign wr  = acc && req_i.we;
  assign idx = req_i.adr.fld.idx;

  always_ff @(posedge clk_125) begin
    if (!rst_n_i) begin
      ack_q     <= 1'b0;
      scratch_q <= '0;
      rate_q    <= '0;
    end else begin
      ack_q <= acc;
      // Scratch merges byte lanes
      if (wr && idx == REG_SCRATCH) begin
        for (int b = 0; b < DW / 8; b++) begin
          if (req_i.sel[b]) begin
            scratch_q[b*8 +: 8] <= req_i.dat[b*8 +: 8];
          end
        end
      end
      // Rate sits in lane 0
      if (wr && idx == REG_RATE && req_i.sel[0]) begin
        rate_q <= req_i.dat[`RATE_W-1:0];
      end
    end
  end

  // Read data lands with ack
  always_ff @(posedge clk_125) begin
    if (acc) begin
      case (idx)
        REG_ID:      rd_q <= `BOARD_ID;
        REG_SCRATCH: rd_q <= scratch_q;
        REG_RATE:    rd_q <= DW'(rate_q);
        default:     rd_q <= '0;
      endcase
    end
  end

  assign rsp_o      = '{ack: ack_q, err: 1'b0, dat: rd_q};
  assign led_rate_o = rate_q;

  // One pulse per access even with stb still high
  a_ack_pulse: assert property (@(posedge clk_125) disable iff (!rst_n_i)
    ack_q |=> !ack_q);

endmodule

//--- source/bus_arbiter.sv
`include "board_defs.svh"

module bus_arbiter (
  input  logic                clk_125,
  input  logic                rst_n_i,
  input  board_pkg::bus_req_t host_req_i,
  output board_pkg::bus_rsp_t host_rsp_o,
  output board_pkg::bus_req_t slv_req_o [`NUM_SLAVES],
  input  board_pkg::bus_rsp_t slv_rsp_i [`NUM_SLAVES]
);

  localparam int TMO_W = $clog2(`BUS_TIMEOUT);
  // First byte past the last mapped page
  localparam logic [15:0] END_PAGE  = `ZDOK1_PAGE + 16'd1;
  localparam logic [31:0] MAP_LIMIT = {END_PAGE, 16'h0000};

  logic [`NUM_SLAVES-1:0] dec;
  logic [`NUM_SLAVES-1:0] grant_q;
  logic [`NUM_SLAVES-1:0] slv_ack;
  logic [`NUM_SLAVES-1:0] slv_err;
  logic                   in_map;
  logic                   idle;
  logic [TMO_W-1:0]       tmo_q;
  logic                   err_q;

  // Page decode, one bit per slave
  always_comb begin
    dec             = '0;
    dec[`SLV_SYS]   = host_req_i.adr.fld.page == `SYS_PAGE;
    dec[`SLV_ZDOK0] = host_req_i.adr.fld.page == `ZDOK0_PAGE;
    dec[`SLV_ZDOK1] = host_req_i.adr.fld.page == `ZDOK1_PAGE;
  end

  // Contiguous map, so one compare finds holes
  assign in_map = host_req_i.adr.flat < MAP_LIMIT;
  assign idle   = grant_q == '0;

  // Request goes only to the granted slave
  always_comb begin
    for (int i = 0; i < `NUM_SLAVES; i++) begin
      slv_req_o[i] = grant_q[i] ? host_req_i : '0;
      slv_ack[i]   = slv_rsp_i[i].ack;
      slv_err[i]   = slv_rsp_i[i].err;
    end
  end

  // Grant held from the first stb cycle until the slave acks
  always_ff @(posedge clk_125) begin
    if (!rst_n_i) begin
      grant_q <= '0;
    end else if (|(grant_q & (slv_ack | slv_err))) begin
      grant_q <= '0;
    end else if (host_req_i.stb && idle) begin
      grant_q <= dec;
    end
  end

  // Timeout runs only on an ungranted hole access
  always_ff @(posedge clk_125) begin
    if (!rst_n_i) begin
      tmo_q <= '0;
      err_q <= 1'b0;
    end else begin
      err_q <= 1'b0;
      if (host_req_i.stb && idle && !in_map) begin
        if (tmo_q == TMO_W'(`BUS_TIMEOUT - 1)) begin
          tmo_q <= '0;
          err_q <= 1'b1;
        end else begin
          tmo_q <= tmo_q + 1'b1;
        end
      end else begin
        tmo_q <= '0;
      end
    end
  end

  // Response back to the host, data zero unless granted
  always_comb begin
    host_rsp_o.ack = |(grant_q & slv_ack);
    host_rsp_o.err = err_q | |(grant_q & slv_err);
    host_rsp_o.dat = '0;
    for (int i = 0; i < `NUM_SLAVES; i++) begin
      if (grant_q[i]) begin
        host_rsp_o.dat = host_rsp_o.dat | slv_rsp_i[i].dat;
      end
    end
  end

  // At most one slave owns the bus
  a_grant_onehot: assert property (@(posedge clk_125) disable iff (!rst_n_i)
    $onehot0(grant_q));

  // A slave answers only while it holds the grant
  a_ack_granted: assert property (@(posedge clk_125) disable iff (!rst_n_i)
    (slv_ack & ~grant_q) == '0);

endmodule

//--- source/board_pkg.sv
`include "board_defs.svh"

package board_pkg;

  // Field view of a byte address
  // Page picks the slave, idx the 32-bit register
  typedef struct packed {
    logic [15:0] page;
    logic [13:0] idx;
    logic [1:0]  lane;
  } bus_addr_fld_t;

  // One address word, two readings
  // Flat for range compares, fields for decode
  typedef union packed {
    logic [31:0]   flat;
    bus_addr_fld_t fld;
  } bus_addr_u;

  // Host or arbiter request
  // Stb held until ack or err
  typedef struct packed {
    logic                   stb;
    logic                   we;
    logic [`BUS_DW/8-1:0]   sel;
    bus_addr_u              adr;
    logic [`BUS_DW-1:0]     dat;
  } bus_req_t;

  // Slave or arbiter response
  // Ack and err are one-cycle pulses
  typedef struct packed {
    logic               ack;
    logic               err;
    logic [`BUS_DW-1:0] dat;
  } bus_rsp_t;

endpackage

//--- source/board_defs.svh
`ifndef BOARD_DEFS_SVH
`define BOARD_DEFS_SVH

// Register bus data width
`define BUS_DW 32

// Slave pages, taken from address bits 31:16
// Pages run contiguous from zero
`define SYS_PAGE   16'h0000
`define ZDOK0_PAGE 16'h0001
`define ZDOK1_PAGE 16'h0002

// Slave slots on the shared bus
`define NUM_SLAVES 3
`define SLV_SYS    0
`define SLV_ZDOK0  1
`define SLV_ZDOK1  2

// Cycles an unmapped access waits for its error
`define BUS_TIMEOUT 64

// Constant at system register 0
`define BOARD_ID 32'hB0A4D001

// Pins per mezzanine bank
`define GPIO_COUNT 80
// Bus words per register kind, 96 bits of room
`define GPIO_WORDS 3

// LED bar width
`define LED_COUNT 8
// Fastest step is 2^LED_BASE_SHIFT cycles
`define LED_BASE_SHIFT 2
// Rate field, adds to the exponent
`define RATE_W 3

`endif
